//--- source/spi_lcd_pkg.sv
// Shared definitions for the SPI LCD master
// Register map, AXI4-Lite channel payloads and the queued command word
package spi_lcd_pkg;

   localparam int axil_addr_w = 4;   // Byte address inside the register map
   localparam int axil_data_w = 32;  // Full word, no strobes

   // Register map, word aligned
   localparam logic [axil_addr_w-1:0] reg_ctrl   = 4'h0;  // Bits 1:0 SCLK divider
   localparam logic [axil_addr_w-1:0] reg_status = 4'h4;  // Busy, full, empty, rx_valid
   localparam logic [axil_addr_w-1:0] reg_txdata = 4'h8;  // Write pushes one command
   localparam logic [axil_addr_w-1:0] reg_rxdata = 4'hC;  // Read clears rx_valid

   // AXI response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // One queued byte, same bit layout as the TXDATA word
   typedef struct packed {
      logic       end_txn;  // Release chip select after this byte
      logic       dc;       // Level for the DC pin
      logic [7:0] data;     // Byte to shift out
   } spi_cmd_t;

   typedef struct packed {
      logic [axil_addr_w-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [axil_addr_w-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [axil_data_w-1:0] data;
   } axil_w_t;

   // Read data channel payload
   typedef struct packed {
      logic [axil_data_w-1:0] data;
      logic [1:0]             resp;
   } axil_r_t;

endpackage

//--- source/axil_spi_regs.sv
// AXI4-Lite register block of the SPI LCD master
// Holds the divider and the last received byte, builds status, pushes TXDATA writes
`timescale 1ns/1ps

module axil_spi_regs #(
   parameter logic [1:0] div_reset = 2'd1  // SCLK divider after reset
) (
   input  logic                  clk,
   input  logic                  rstn,
   // Write address and write data, accepted together
   input  logic                  awvalid,
   output logic                  awready,
   input  spi_lcd_pkg::axil_aw_t aw,
   input  logic                  wvalid,
   output logic                  wready,
   input  spi_lcd_pkg::axil_w_t  w,
   // Write response
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   // Read address and read data
   input  logic                  arvalid,
   output logic                  arready,
   input  spi_lcd_pkg::axil_ar_t ar,
   output logic                  rvalid,
   input  logic                  rready,
   output spi_lcd_pkg::axil_r_t  r,
   // Command queue
   input  logic                  full,
   input  logic                  empty,
   output logic                  push_valid,
   output spi_lcd_pkg::spi_cmd_t push_cmd,
   // Byte engine
   input  logic                  busy,
   input  logic                  rx_strobe,
   input  logic [7:0]            rx_byte,
   output logic [1:0]            divider
);
   import spi_lcd_pkg::*;

   logic                   wr_accept;  // AW and W taken this cycle
   logic                   rd_accept;  // AR taken this cycle
   logic [1:0]             wr_resp;
   logic [axil_data_w-1:0] rd_data;
   logic [1:0]             rd_resp;
   logic [7:0]             rx_data;    // Last byte from MISO
   logic                   rx_valid;

   // One write at a time, both channels in the same cycle
   assign wr_accept = awvalid & wvalid & ~bvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign arready   = ~rvalid;                 // No new read while R is pending
   assign rd_accept = arvalid & arready;

   // TXDATA write goes straight into the queue unless it is full
   assign push_valid = wr_accept & (aw.addr == reg_txdata) & ~full;
   assign push_cmd   = spi_cmd_t'(w.data[9:0]);

   always_comb begin
      case (aw.addr)
         reg_ctrl, reg_status, reg_rxdata: wr_resp = resp_okay;
         reg_txdata: wr_resp = full ? resp_slverr : resp_okay;  // Dropped push
         default:    wr_resp = resp_slverr;
      endcase
   end

   // Read mux, unused offsets answer SLVERR
   always_comb begin
      rd_data = '0;
      rd_resp = resp_okay;
      case (ar.addr)
         reg_ctrl:   rd_data[1:0] = divider;
         reg_status: rd_data[3:0] = {rx_valid, empty, full, busy};
         reg_txdata: rd_data = '0;              // Write only, reads as zero
         reg_rxdata: rd_data[7:0] = rx_data;
         default:    rd_resp = resp_slverr;
      endcase
   end

   // B channel and divider
   always_ff @(posedge clk) begin
      if (!rstn) begin
         bvalid  <= 1'b0;
         divider <= div_reset;
      end else begin
         if (wr_accept) begin
            bvalid <= 1'b1;                    // Response one cycle after acceptance
            if (aw.addr == reg_ctrl) begin
               divider <= w.data[1:0];         // Engine picks it up at next command
            end
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         bresp <= wr_resp;
      end
   end

   // R channel and receive flag
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rvalid   <= 1'b0;
         rx_valid <= 1'b0;
      end else begin
         if (rd_accept) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         // A fresh byte wins over a read that clears the flag
         if (rx_strobe) begin
            rx_valid <= 1'b1;
         end else if (rd_accept && ar.addr == reg_rxdata) begin
            rx_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept) begin
         r.data <= rd_data;
         r.resp <= rd_resp;
      end
      if (rx_strobe) begin
         rx_data <= rx_byte;                   // Only the last byte is kept
      end
   end

endmodule

//--- source/spi_cmd_fifo.sv
// Command queue between the register block and the byte engine
// Circular buffer with an occupancy count, push and pop in the same cycle allowed
`timescale 1ns/1ps

module spi_cmd_fifo #(
   parameter int fifo_depth = 4  // Number of queued commands
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  push_valid,
   input  spi_lcd_pkg::spi_cmd_t push_cmd,
   output logic                  full,
   output logic                  empty,
   output logic                  cmd_valid,
   output spi_lcd_pkg::spi_cmd_t cmd,
   input  logic                  cmd_ready
);
   import spi_lcd_pkg::*;

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   spi_cmd_t         mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;    // Entries held
   logic             push;
   logic             pop;

   assign full      = (count == cnt_w'(fifo_depth));
   assign empty     = (count == '0);
   assign cmd_valid = ~empty;
   assign cmd       = mem[rd_ptr];           // Head of queue
   assign push      = push_valid & ~full;    // Extra push is ignored
   assign pop       = cmd_valid & cmd_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_cmd;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;         // Both or neither
         endcase
      end
   end

endmodule

//--- source/spi_byte_engine.sv
// SPI mode 0 byte engine, MSB first
// Takes one command, shifts its byte out on MOSI and captures one byte from MISO
`timescale 1ns/1ps

module spi_byte_engine (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  cmd_valid,
   input  spi_lcd_pkg::spi_cmd_t cmd,
   output logic                  cmd_ready,
   input  logic [1:0]            divider,      // Half period is divider+1 clocks
   output logic                  busy,
   output logic [7:0]            rx_byte,
   output logic                  rx_strobe,    // One cycle, as busy falls
   input  logic                  spi_miso,
   output logic                  spi_select,   // Active low
   output logic                  spi_clk_out,
   output logic                  spi_mosi,
   output logic                  spi_dc
);

   logic [7:0] tx_sh;       // Outgoing bits, MSB on the pin
   logic [7:0] rx_sh;       // Incoming bits
   logic       end_txn_l;
   logic [1:0] div_l;       // Divider latched per byte
   logic [1:0] half_cnt;    // Clocks into current half period
   logic [2:0] bit_cnt;     // Bits left after the current one
   logic       take;
   logic       half_done;   // SCLK edge this cycle

   assign cmd_ready = ~busy;                 // Only idle takes a command
   assign take      = cmd_valid & cmd_ready;
   assign half_done = busy & (half_cnt == div_l);
   assign spi_mosi  = tx_sh[7];
   assign rx_byte   = rx_sh;                 // Stable until next rising edge

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy        <= 1'b0;
         spi_select  <= 1'b1;
         spi_clk_out <= 1'b0;
         half_cnt    <= '0;
         bit_cnt     <= '0;
         rx_strobe   <= 1'b0;
      end else begin
         rx_strobe <= 1'b0;
         if (take) begin
            busy        <= 1'b1;
            spi_select  <= 1'b0;             // Falls on the cycle the command is taken
            spi_clk_out <= 1'b0;
            half_cnt    <= '0;
            bit_cnt     <= 3'd7;
         end else if (busy) begin
            if (half_done) begin
               half_cnt    <= '0;
               spi_clk_out <= ~spi_clk_out;
               // Falling edge closes a bit
               if (spi_clk_out) begin
                  if (bit_cnt == '0) begin
                     busy       <= 1'b0;
                     spi_select <= end_txn_l;  // Stays low inside a transaction
                     rx_strobe  <= 1'b1;
                  end else begin
                     bit_cnt <= bit_cnt - 1'b1;
                  end
               end
            end else begin
               half_cnt <= half_cnt + 1'b1;
            end
         end
      end
   end

   // Data path
   always_ff @(posedge clk) begin
      if (take) begin
         tx_sh     <= cmd.data;
         spi_dc    <= cmd.dc;
         end_txn_l <= cmd.end_txn;
         div_l     <= divider;
      end else if (half_done) begin
         if (spi_clk_out) begin
            tx_sh <= {tx_sh[6:0], 1'b0};     // Shift on falling edge
         end else begin
            rx_sh <= {rx_sh[6:0], spi_miso};  // Sample on rising edge
         end
      end
   end

endmodule

//--- source/spi_lcd_top.sv
// SPI LCD master top level
// AXI4-Lite registers feed a command queue that drives the SPI byte engine
`timescale 1ns/1ps

module spi_lcd_top #(
   parameter int         fifo_depth = 4,     // Command queue entries
   parameter logic [1:0] div_reset  = 2'd1   // SCLK divider after reset
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  awvalid,
   output logic                  awready,
   input  spi_lcd_pkg::axil_aw_t aw,
   input  logic                  wvalid,
   output logic                  wready,
   input  spi_lcd_pkg::axil_w_t  w,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [1:0]            bresp,
   input  logic                  arvalid,
   output logic                  arready,
   input  spi_lcd_pkg::axil_ar_t ar,
   output logic                  rvalid,
   input  logic                  rready,
   output spi_lcd_pkg::axil_r_t  r,
   input  logic                  spi_miso,
   output logic                  spi_select,
   output logic                  spi_clk_out,
   output logic                  spi_mosi,
   output logic                  spi_dc
);
   import spi_lcd_pkg::*;

   logic       push_valid;
   spi_cmd_t   push_cmd;
   logic       full;
   logic       empty;
   logic       cmd_valid;
   spi_cmd_t   cmd;          // Queue head
   logic       cmd_ready;
   logic [1:0] divider;
   logic       busy;
   logic [7:0] rx_byte;
   logic       rx_strobe;

   axil_spi_regs #(
      .div_reset (div_reset)
   ) regs_i (
      .clk        (clk),
      .rstn       (rstn),
      .awvalid    (awvalid),
      .awready    (awready),
      .aw         (aw),
      .wvalid     (wvalid),
      .wready     (wready),
      .w          (w),
      .bvalid     (bvalid),
      .bready     (bready),
      .bresp      (bresp),
      .arvalid    (arvalid),
      .arready    (arready),
      .ar         (ar),
      .rvalid     (rvalid),
      .rready     (rready),
      .r          (r),
      .full       (full),
      .empty      (empty),
      .push_valid (push_valid),
      .push_cmd   (push_cmd),
      .busy       (busy),
      .rx_strobe  (rx_strobe),
      .rx_byte    (rx_byte),
      .divider    (divider)
   );

   spi_cmd_fifo #(
      .fifo_depth (fifo_depth)
   ) fifo_i (
      .clk        (clk),
      .rstn       (rstn),
      .push_valid (push_valid),
      .push_cmd   (push_cmd),
      .full       (full),
      .empty      (empty),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_ready  (cmd_ready)
   );

   spi_byte_engine engine_i (
      .clk         (clk),
      .rstn        (rstn),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .cmd_ready   (cmd_ready),
      .divider     (divider),
      .busy        (busy),
      .rx_byte     (rx_byte),
      .rx_strobe   (rx_strobe),
      .spi_miso    (spi_miso),
      .spi_select  (spi_select),
      .spi_clk_out (spi_clk_out),
      .spi_mosi    (spi_mosi),
      .spi_dc      (spi_dc)
   );

endmodule

//--- test/spi_lcd_assert.sv
// Concurrent checks on the SPI LCD master, bound into the top level
// SPI line behaviour around the byte engine and AXI4-Lite response holding
`timescale 1ns/1ps

module spi_lcd_assert (
   input logic clk,
   input logic rstn,
   input logic busy,
   input logic spi_select,
   input logic spi_clk_out,
   input logic spi_mosi,
   input logic spi_dc,
   input logic bvalid,
   input logic bready,
   input logic rvalid,
   input logic rready
);

   logic failed = 1'b0;  // Sticky, set by any failing property

   reset_state: assert property (@(posedge clk) $rose(rstn) |-> spi_select && !spi_clk_out && !busy)
      else begin
         failed = 1'b1;
         $error("SPI lines or busy not inactive after reset");
      end

   // SCLK parks low between bytes
   sclk_idle: assert property (@(posedge clk) disable iff (!rstn) !busy |-> !spi_clk_out)
      else begin
         failed = 1'b1;
         $error("spi_clk_out high while the engine is idle");
      end

   lines_stable: assert property (@(posedge clk) disable iff (!rstn)
                                  spi_clk_out |-> $stable(spi_mosi) && $stable(spi_dc))
      else begin
         failed = 1'b1;
         $error("spi_mosi or spi_dc changed while spi_clk_out was high");
      end

   select_rise: assert property (@(posedge clk) disable iff (!rstn) $rose(spi_select) |-> !busy)
      else begin
         failed = 1'b1;
         $error("spi_select rose during a byte");
      end

   b_hold: assert property (@(posedge clk) disable iff (!rstn) bvalid && !bready |=> bvalid)
      else begin
         failed = 1'b1;
         $error("bvalid dropped before bready");
      end

   r_hold: assert property (@(posedge clk) disable iff (!rstn) rvalid && !rready |=> rvalid)
      else begin
         failed = 1'b1;
         $error("rvalid dropped before rready");
      end

endmodule

bind spi_lcd_top spi_lcd_assert assert_i (
   .clk         (clk),
   .rstn        (rstn),
   .busy        (busy),
   .spi_select  (spi_select),
   .spi_clk_out (spi_clk_out),
   .spi_mosi    (spi_mosi),
   .spi_dc      (spi_dc),
   .bvalid      (bvalid),
   .bready      (bready),
   .rvalid      (rvalid),
   .rready      (rready)
);

//--- test/spi_lcd_tb.sv
// Testbench for the SPI LCD master
// AXI4-Lite master tasks, a mode 0 SPI slave model with LFSR replies, value checks
`timescale 1ns/1ps

module spi_lcd_tb;
   import spi_lcd_pkg::*;

   localparam int fifo_depth     = 4;
   localparam int timeout_cycles = 4000;  // 13 bytes of up to 64 clocks, AXI traffic, margin

   logic           clk;
   logic           rstn;
   logic           awvalid, wvalid, bready, arvalid, rready;
   logic           awready, wready, bvalid, arready, rvalid;
   logic [1:0]     bresp;
   axil_aw_t       aw;
   axil_w_t        w;
   axil_ar_t       ar;
   axil_r_t        r;
   logic           spi_miso, spi_select, spi_clk_out, spi_mosi, spi_dc;

   logic [15:0]    lfsr = 16'd43318;
   int             cycles = 0;
   int             cur_div = 1;     // Divider the engine latches for the next byte
   int             bit_idx = 0;     // Rising SCLK edges in the current byte
   int             txn_bytes = 0;
   int             rise_cycle = 0;
   int             fall_cycle = 0;
   logic [7:0]     rx_shift, reply, last_reply, exp_byte;
   logic           exp_bit;
   logic [7:0]     exp_data [$];
   logic           exp_dc [$];
   int             txn_lens [$];    // Bytes per chip select frame

   spi_lcd_top #(.fifo_depth(fifo_depth), .div_reset(2'd1)) spi_lcd_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
   function automatic logic [7:0] lfsr_bits(input int n);
      logic [7:0] val;
      logic       fb;
      int         i;
      val = '0;
      for (i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         val  = {val[6:0], fb};
      end
      return val;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic check(input logic ok, input string msg);
      assert (ok) else stop_run($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
   endtask

   task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] wr_resp);
      @(posedge clk);
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      aw.addr <= addr;
      w.data  <= data;
      do begin
         @(posedge clk);
      end while (!(awready && wready));
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      while (!bvalid) begin
         @(posedge clk);
      end
      wr_resp = bresp;
      bready <= 1'b1;  // One cycle late, B must hold
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] rd_resp);
      @(posedge clk);
      arvalid <= 1'b1;
      ar.addr <= addr;
      do begin
         @(posedge clk);
      end while (!arready);
      arvalid <= 1'b0;
      while (!rvalid) begin
         @(posedge clk);
      end
      data    = r.data;
      rd_resp = r.resp;
      rready <= 1'b1;
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // Expected values are queued before the write, the engine may start right away
   task automatic push_byte(input logic [7:0] data, input logic dc, input logic end_txn);
      logic [1:0] rsp;
      exp_data.push_back(data);
      exp_dc.push_back(dc);
      axil_write(reg_txdata, {22'd0, end_txn, dc, data}, rsp);
      check(rsp == resp_okay, "TXDATA write not answered with OKAY");
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      logic [1:0]  rsp;
      st = 32'h1;
      while (st[0] || !st[2]) begin
         axil_read(reg_status, st, rsp);
      end
      check(exp_data.size() == 0, "pushed bytes never appeared on the SPI bus");
   endtask

   task automatic check_rx();
      logic [31:0] data;
      logic [1:0]  rsp;
      axil_read(reg_status, data, rsp);
      check(data[3] == 1'b1, "rx_valid not set after a byte");
      axil_read(reg_rxdata, data, rsp);
      check(data[7:0] == last_reply,
            $sformatf("RXDATA %02h, expected %02h", data[7:0], last_reply));
      axil_read(reg_status, data, rsp);
      check(data[3] == 1'b0, "rx_valid not cleared by the RXDATA read");
   endtask

   task automatic set_divider(input logic [1:0] div);
      logic [31:0] data;
      logic [1:0]  rsp;
      axil_write(reg_ctrl, {30'd0, div}, rsp);
      cur_div = div;
      axil_read(reg_ctrl, data, rsp);
      check(rsp == resp_okay && data[1:0] == div,
            $sformatf("CTRL reads %0d, expected %0d", data[1:0], div));
   endtask

   // SPI slave model, mode 0, MSB first
   always @(negedge spi_select) begin
      reply = lfsr_bits(8);
      spi_miso <= reply[7];
   end

   always @(posedge spi_clk_out) begin
      if (rstn) begin
         if (bit_idx == 0) begin
            check(exp_dc.size() != 0, "SPI byte started with no command pushed");
            exp_bit = exp_dc.pop_front();
            check(spi_dc == exp_bit, $sformatf("DC %b, expected %b", spi_dc, exp_bit));
            last_reply = reply;
         end else begin
            check(cycles - fall_cycle == cur_div + 1,
                  $sformatf("SCLK low for %0d clocks", cycles - fall_cycle));
         end
         rx_shift   = {rx_shift[6:0], spi_mosi};
         bit_idx    = bit_idx + 1;
         rise_cycle = cycles;
         if (bit_idx == 8) begin
            exp_byte = exp_data.pop_front();
            check(rx_shift == exp_byte, $sformatf("MOSI %02h, expected %02h", rx_shift, exp_byte));
            txn_bytes = txn_bytes + 1;
         end
      end
   end

   always @(negedge spi_clk_out) begin
      if (rstn) begin
         check(cycles - rise_cycle == cur_div + 1,
               $sformatf("SCLK high for %0d clocks", cycles - rise_cycle));
         fall_cycle = cycles;
         if (bit_idx == 8) begin
            bit_idx = 0;                       // Next byte may follow at once
            reply = lfsr_bits(8);
            spi_miso <= reply[7];
         end else begin
            spi_miso <= reply[7 - bit_idx];
         end
      end
   end

   always @(posedge spi_select) begin
      if (rstn) begin
         check(bit_idx == 0 || bit_idx == 8, "chip select rose inside a byte");
         txn_lens.push_back(txn_bytes);
         txn_bytes = 0;
      end
   end

   // Cycle count, timeout and concurrent assertion watch
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > timeout_cycles) begin
         stop_run($sformatf("Timeout: the run did not finish in %0d cycles", timeout_cycles));
      end else if (spi_lcd_top_i.assert_i.failed) begin
         stop_run("A concurrent assertion on the DUT failed");
      end
   end

   initial begin
      logic [31:0] data;
      logic [1:0]  rsp;
      int          i;
      rstn     = 1'b0;
      awvalid  = 1'b0;
      wvalid   = 1'b0;
      bready   = 1'b0;
      arvalid  = 1'b0;
      rready   = 1'b0;
      aw       = '0;
      w        = '0;
      ar       = '0;
      spi_miso = 1'b0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;

      // Reset state
      axil_read(reg_status, data, rsp);
      check(rsp == resp_okay && data[3:0] == 4'b0100, $sformatf("STATUS %h after reset", data));
      axil_read(reg_ctrl, data, rsp);
      check(data[1:0] == 2'd1, $sformatf("CTRL %0d after reset", data[1:0]));

      // Single bytes with random data and DC, each read back from RXDATA
      for (i = 0; i < 3; i++) begin
         push_byte(lfsr_bits(8), lfsr_bits(1) != 8'd0, 1'b1);
         wait_idle();
         check_rx();
      end

      // Three bytes in one chip select frame
      push_byte(lfsr_bits(8), 1'b0, 1'b0);
      push_byte(lfsr_bits(8), 1'b1, 1'b0);
      push_byte(lfsr_bits(8), 1'b1, 1'b1);
      wait_idle();
      check(txn_lens.size() != 0 && txn_lens[$] == 3, "chip select did not frame three bytes");
      check_rx();

      // Fastest and slowest SCLK
      set_divider(2'd0);
      push_byte(lfsr_bits(8), 1'b1, 1'b1);
      wait_idle();
      check_rx();
      set_divider(2'd3);
      push_byte(lfsr_bits(8), 1'b0, 1'b1);
      wait_idle();
      check_rx();

      // Engine takes the first byte, the queue holds the rest
      for (i = 0; i <= fifo_depth; i++) begin
         push_byte(lfsr_bits(8), 1'b0, i == fifo_depth);
      end
      axil_read(reg_status, data, rsp);
      check(data[1] == 1'b1, $sformatf("STATUS %h does not show a full queue", data));
      axil_write(reg_txdata, 32'h2a5, rsp);
      check(rsp == resp_slverr, "push into a full queue not answered with SLVERR");
      axil_read(4'h6, data, rsp);
      check(rsp == resp_slverr, "read of an unused address not answered with SLVERR");
      axil_write(4'h6, 32'h1, rsp);
      check(rsp == resp_slverr, "write to an unused address not answered with SLVERR");
      wait_idle();
      check(txn_lens[$] == fifo_depth + 1,
            $sformatf("%0d bytes in the last frame, expected %0d", txn_lens[$], fifo_depth + 1));

      if (spi_lcd_top_i.assert_i.failed) begin
         stop_run("A concurrent assertion on the DUT failed");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

//--- sources.f
source/spi_lcd_pkg.sv
source/axil_spi_regs.sv
source/spi_cmd_fifo.sv
source/spi_byte_engine.sv
source/spi_lcd_top.sv
test/spi_lcd_assert.sv
test/spi_lcd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI LCD master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module spi_lcd_tb -f sources.f -o spi_lcd_sim

# Keep running after an assertion error so the testbench can report it
./obj_dir/spi_lcd_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
